// File: Makefile
TOP := jsonUartTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: dv/jsonUartTb.sv
`timescale 1ns/1ps
`default_nettype none

module jsonUartTb import motionPkg::*, uartPkg::*; ();

    localparam int clksPerBit  = 8;
    localparam int gapCycles   = 20;
    localparam int frameCycles = 11 * clksPerBit;      // Start, 8 data, parity, stop
    localparam int msgTimeout  = 4000;                 // Cycles allowed per message

    // Wheel text indexed by motion code
    localparam string leftVal[7]  = '{"0", "-0.00", "0.12", "0.05", "0.25", "0.5", "-0.25"};
    localparam string rightVal[7] = '{"0", "0.12", "-0.00", "0.05", "0.25", "0.5", "0.25"};

    logic          clk;
    logic          rst;
    motion_e       motionCode;
    logic          txd;
    senderStatus_t status;

    int          cycle;
    logic [31:0] rngState;
    logic [2:0]  codeAtEdge;                           // Code the DUT saw at the last rising edge
    logic [2:0]  expMotionQ[$];                        // Codes latched at busy rise
    logic [7:0]  rxByteQ[$];
    int          rxStartQ[$];                          // Start-edge cycle of each byte
    logic        inFrame;
    logic        prevBusy;
    logic        prevDone;
    logic        pendingDone;                          // Message finished but done not yet seen
    logic [2:0]  curMotion;
    logic [2:0]  lastMotion;
    int          msgPos;
    int          prevStart;
    int          lastFrameEnd;
    int          msgCount;
    int          codeMsgs[8];
    int          dataErrors;
    int          frameErrors;
    int          timingErrors;
    int          statusErrors;
    int          timeoutErrors;

    jsonUartTop #(
        .clksPerBit (clksPerBit),
        .parityMode (EVEN),
        .gapCycles  (gapCycles)
    ) u_jsonUartTop (
        .clk        (clk),
        .rst        (rst),
        .motionCode (motionCode),
        .txd        (txd),
        .status     (status)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle      <= cycle + 1;
        codeAtEdge <= motionCode;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int randomBelow(input int n);
        rngState = lcgNext(rngState);
        return int'(rngState[30:8]) % n;               // Upper bits have the longer period
    endfunction

    function automatic logic [2:0] effectiveMotion(input logic [2:0] code);
        return (code == 3'd7) ? 3'd0 : code;           // Code 7 sends stop
    endfunction

    function automatic string refMessage(input logic [2:0] code);
        int m;
        m = int'(effectiveMotion(code));
        return {"{\"T\":1,\"L\":", leftVal[m], ",\"R\":", rightVal[m], "}\n"};
    endfunction

    task automatic skipCycles(input int n, inout logic aborted);
        int i;
        for (i = 0; i < n && !aborted; i++) begin
            @(negedge clk);
            if (rst) aborted = 1'b1;                   // Frame cut by reset
        end
    endtask

    task automatic decodeFrame();
        logic       aborted;
        logic       startBit;
        logic       parityBit;
        logic [7:0] data;
        int         startCycle;
        int         i;
        aborted    = 1'b0;
        startCycle = cycle;
        inFrame    = 1'b1;
        skipCycles(clksPerBit / 2, aborted);           // Middle of start bit
        startBit = txd;
        for (i = 0; i < 8; i++) begin
            skipCycles(clksPerBit, aborted);
            data[i] = txd;                             // LSB first
        end
        skipCycles(clksPerBit, aborted);
        parityBit = txd;
        skipCycles(clksPerBit, aborted);
        if (!aborted) begin
            if (startBit !== 1'b0) begin
                $display("** Error at %0t: start bit not low (cycle %0d)", $time, startCycle);
                frameErrors++;
            end
            if (((^data) ^ parityBit) !== 1'b0) begin
                $display("** Error at %0t: odd count of ones with parity, data %02h parity %b",
                         $time, data, parityBit);
                frameErrors++;
            end
            if (txd !== 1'b1) begin
                $display("** Error at %0t: stop bit not high after byte %02h", $time, data);
                frameErrors++;
            end
            rxByteQ.push_back(data);
            rxStartQ.push_back(startCycle);
        end
        inFrame = 1'b0;
    endtask

    initial begin
        inFrame = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && txd === 1'b0) begin
                decodeFrame();
            end
        end
    end

    // Status monitor and byte compare at the falling edge
    always @(negedge clk) begin : compareBytes
        logic [7:0] got;
        int         startAt;
        string      expMsg;
        if (rst) begin
            expMotionQ.delete();
            rxByteQ.delete();
            rxStartQ.delete();
            msgPos       = 0;
            prevStart    = 0;
            lastFrameEnd = -1;                         // No gap check on the first message
            pendingDone  = 1'b0;
            prevBusy     = 1'b0;
            prevDone     = 1'b0;
            curMotion    = 3'd0;
            lastMotion   = 3'd0;
        end else begin
            if (status.busy && !prevBusy) begin
                expMotionQ.push_back(codeAtEdge);      // Latched on this rise
            end
            if (status.done) begin
                if (prevDone) begin
                    $display("** Error at %0t: done high for more than one cycle", $time);
                    statusErrors++;
                end
                if (status.busy) begin
                    $display("** Error at %0t: busy high while done", $time);
                    statusErrors++;
                end
                if (!pendingDone) begin
                    $display("** Error at %0t: done without a finished message", $time);
                    statusErrors++;
                end
                if (cycle - prevStart < frameCycles) begin
                    $display("** Error at %0t: done %0d cycles after last start edge",
                             $time, cycle - prevStart);
                    timingErrors++;
                end
                if (status.activeMotion !== motion_e'(effectiveMotion(lastMotion))) begin
                    $display("** Error at %0t: activeMotion %0d, expected %0d", $time,
                             status.activeMotion, effectiveMotion(lastMotion));
                    statusErrors++;
                end
                pendingDone = 1'b0;
            end
            if (rxByteQ.size() > 0) begin
                got     = rxByteQ.pop_front();
                startAt = rxStartQ.pop_front();
                if (msgPos == 0) begin
                    if (expMotionQ.size() == 0) begin
                        $display("** Error at %0t: byte %02h before busy rose", $time, got);
                        statusErrors++;
                        curMotion = 3'd0;
                    end else begin
                        curMotion = expMotionQ.pop_front();
                    end
                    if (lastFrameEnd >= 0 && startAt - lastFrameEnd < gapCycles) begin
                        $display("** Error at %0t: gap of %0d cycles between messages",
                                 $time, startAt - lastFrameEnd);
                        timingErrors++;
                    end
                end else if (startAt - prevStart != frameCycles) begin
                    $display("** Error at %0t: start edges %0d cycles apart inside message",
                             $time, startAt - prevStart);
                    timingErrors++;
                end
                expMsg = refMessage(curMotion);
                if (got !== 8'(expMsg[msgPos])) begin
                    $display("** Error at %0t: motion %0d byte %0d is %02h, expected %02h",
                             $time, curMotion, msgPos, got, 8'(expMsg[msgPos]));
                    dataErrors++;
                end
                prevStart = startAt;
                msgPos++;
                if (msgPos == expMsg.len()) begin
                    if (pendingDone) begin
                        $display("** Error at %0t: no done for previous message", $time);
                        statusErrors++;
                    end
                    pendingDone  = 1'b1;
                    lastMotion   = curMotion;
                    lastFrameEnd = startAt + frameCycles;
                    msgPos       = 0;
                    msgCount++;
                    codeMsgs[curMotion]++;
                end
            end
            prevBusy = status.busy;
            prevDone = status.done;
        end
    end

    task automatic finishRun();
        int total;
        total = dataErrors + frameErrors + timingErrors + statusErrors + timeoutErrors;
        $display("Errors: data %0d, frame %0d, timing %0d, status %0d, timeout %0d (%0d messages)",
                 dataErrors, frameErrors, timingErrors, statusErrors, timeoutErrors, msgCount);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic waitMessages(input int n);
        int target;
        int waited;
        target = msgCount + n;
        waited = 0;
        while (msgCount < target && waited < n * msgTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (msgCount < target) begin
            $display("Timeout: only %0d of %0d messages arrived in %0d cycles",
                     n - (target - msgCount), n, waited);
            timeoutErrors++;
            finishRun();
        end
    endtask

    task automatic waitFrame();
        int waited;
        waited = 0;
        while (!(inFrame && status.busy) && waited < msgTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!(inFrame && status.busy)) begin
            $display("Timeout: no frame on the line within %0d cycles", waited);
            timeoutErrors++;
            finishRun();
        end
    endtask

    task automatic waitDoneClear();
        int waited;
        waited = 0;
        while (pendingDone && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (pendingDone) begin
            $display("The done pulse for the final message never came");
            statusErrors++;
        end
    endtask

    initial begin
        int code;
        rst           = 1'b1;
        motionCode    = STOP;
        rngState      = 32'h8bf7d9cc;
        msgCount      = 0;
        dataErrors    = 0;
        frameErrors   = 0;
        timingErrors  = 0;
        statusErrors  = 0;
        timeoutErrors = 0;
        for (code = 0; code < 8; code++) begin
            codeMsgs[code] = 0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Each code held for two full messages
        for (code = 0; code < 8; code++) begin
            @(negedge clk);
            motionCode = motion_e'(3'(code));
            waitMessages(2);
        end

        // Code changes at random points in the middle of messages
        repeat (12) begin
            repeat (200 + randomBelow(2400)) @(negedge clk);
            motionCode = motion_e'(3'(randomBelow(8)));
        end
        waitMessages(2);

        // Reset in the middle of a frame
        repeat (2) begin
            waitFrame();
            repeat (3 * clksPerBit) @(negedge clk);
            rst = 1'b1;
            @(negedge clk);
            if (txd !== 1'b1 || status.busy !== 1'b0) begin
                $display("** Error at %0t: txd %b busy %b one cycle into reset", $time,
                         txd, status.busy);
                statusErrors++;
            end
            @(negedge clk);
            rst = 1'b0;
            waitMessages(2);
        end

        waitDoneClear();
        for (code = 0; code < 8; code++) begin
            if (codeMsgs[code] == 0) begin
                $display("No complete message was received for motion code %0d", code);
                statusErrors++;
            end
        end
        finishRun();
    end

endmodule

`default_nettype wire

// File: hdl/cmdMessageRom.sv
`timescale 1ns/1ps
`default_nettype none

module cmdMessageRom import motionPkg::*; (
    input  motion_e                motion,
    input  logic [msgIndexW-1:0]   msgIndex,
    output msgByte_t               msgByte
);

    // Wheel speed text, right aligned in the field
    typedef struct packed {
        logic [2:0]  len;           // Characters in use
        logic [39:0] text;
    } wheelText_t;

    localparam logic [87:0] headText = "{\"T\":1,\"L\":";
    localparam logic [39:0] midText  = ",\"R\":";
    localparam int          headLen  = 11;
    localparam int          midLen   = 5;

    wheelText_t leftWheel;
    wheelText_t rightWheel;

    // Character pos of a right aligned string of len characters
    function automatic logic [7:0] charAt(
        input logic [87:0] text,
        input int          len,
        input int          pos
    );
        return text[(len - 1 - pos) * 8 +: 8];
    endfunction

    // Wheel values per motion
    always_comb begin
        case (motion)
            LEFT: begin
                leftWheel  = '{3'd5, 40'("-0.00")};
                rightWheel = '{3'd4, 40'("0.12")};
            end
            RIGHT: begin
                leftWheel  = '{3'd4, 40'("0.12")};
                rightWheel = '{3'd5, 40'("-0.00")};
            end
            FWD_SLOW: begin
                leftWheel  = '{3'd4, 40'("0.05")};
                rightWheel = '{3'd4, 40'("0.05")};
            end
            FWD_MED: begin
                leftWheel  = '{3'd4, 40'("0.25")};
                rightWheel = '{3'd4, 40'("0.25")};
            end
            FWD_FAST: begin
                leftWheel  = '{3'd3, 40'("0.5")};
                rightWheel = '{3'd3, 40'("0.5")};
            end
            REVERSE: begin
                leftWheel  = '{3'd5, 40'("-0.25")};
                rightWheel = '{3'd4, 40'("0.25")};
            end
            default: begin                              // STOP and code 7
                leftWheel  = '{3'd1, 40'("0")};
                rightWheel = '{3'd1, 40'("0")};
            end
        endcase
    end

    // Segment walk: head, left value, middle, right value, brace, newline
    always_comb begin
        int idx;
        int leftEnd;
        int midEnd;
        int rightEnd;
        idx      = int'(msgIndex);
        leftEnd  = headLen + int'(leftWheel.len);       // First index past each segment
        midEnd   = leftEnd + midLen;
        rightEnd = midEnd + int'(rightWheel.len);
        msgByte.last = 1'b0;
        if (idx < headLen) begin
            msgByte.data = charAt(headText, headLen, idx);
        end else if (idx < leftEnd) begin
            msgByte.data = charAt({48'd0, leftWheel.text}, int'(leftWheel.len), idx - headLen);
        end else if (idx < midEnd) begin
            msgByte.data = charAt({48'd0, midText}, midLen, idx - leftEnd);
        end else if (idx < rightEnd) begin
            msgByte.data = charAt({48'd0, rightWheel.text}, int'(rightWheel.len), idx - midEnd);
        end else if (idx == rightEnd) begin
            msgByte.data = 8'h7D;                       // Closing brace
        end else begin
            msgByte.data = 8'h0A;                       // Newline, also past the end
            msgByte.last = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cmdSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmdSequencer import motionPkg::*; #(
    parameter int gapCycles = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  motion_e              motionCode,
    input  msgByte_t             msgByte,
    input  logic                 txReady,
    output motion_e              motion,
    output logic [msgIndexW-1:0] msgIndex,
    output logic [7:0]           txByte,
    output logic                 txValid,
    output senderStatus_t        status
);

    localparam int gapW = (gapCycles > 0) ? $clog2(gapCycles + 1) : 1;

    typedef enum logic [1:0] {
        GAP,                                    // Idle time before a message
        SEND,                                   // Offering bytes to the transmitter
        DRAIN,                                  // Last byte on the line
        DONE                                    // End-of-message pulse
    } seqState_e;

    seqState_e       state;
    logic [gapW-1:0] gapCnt;
    logic            handoff;

    assign txValid = (state == SEND);
    assign txByte  = msgByte.data;              // Store is combinational
    assign handoff = txValid && txReady;

    assign status.busy         = (state == SEND) || (state == DRAIN);
    assign status.done         = (state == DONE);
    assign status.activeMotion = motion;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= GAP;
            gapCnt   <= '0;
            msgIndex <= '0;
            motion   <= STOP;
        end else begin
            case (state)
                GAP: begin
                    if (gapCnt == gapW'(gapCycles)) begin
                        gapCnt   <= '0;
                        msgIndex <= '0;
                        // Latch once per message, code 7 becomes stop
                        motion   <= (motionCode > REVERSE) ? STOP : motionCode;
                        state    <= SEND;
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
                SEND: begin
                    if (handoff) begin
                        if (msgByte.last) begin
                            state <= DRAIN;
                        end else begin
                            msgIndex <= msgIndex + 1'b1;    // Next character
                        end
                    end
                end
                DRAIN: begin
                    if (txReady) begin                      // Stop bit finished
                        state <= DONE;
                    end
                end
                default: begin
                    state <= GAP;
                end
            endcase
        end
    end

    // Offer held until the transmitter takes it
    validHeld: assert property (@(posedge clk) disable iff (rst)
        txValid && !txReady |=> txValid)
        else $error("txValid dropped before handoff");

    byteStable: assert property (@(posedge clk) disable iff (rst)
        txValid && !txReady |=> $stable(txByte))
        else $error("txByte changed while waiting for txReady");

endmodule

`default_nettype wire

// File: hdl/jsonUartTop.sv
`timescale 1ns/1ps
`default_nettype none

module jsonUartTop import motionPkg::*, uartPkg::*; #(
    parameter int      clksPerBit = 434,            // 115200 baud at 50 MHz
    parameter parity_e parityMode = NONE,
    parameter int      gapCycles  = 0               // Idle cycles between messages
) (
    input  logic          clk,
    input  logic          rst,
    input  motion_e       motionCode,
    output logic          txd,
    output senderStatus_t status
);

    motion_e              motion;                   // Latched per message
    logic [msgIndexW-1:0] msgIndex;
    msgByte_t             msgByte;
    logic [7:0]           txByte;
    logic                 txValid;
    logic                 txReady;

    cmdMessageRom u_cmdMessageRom (
        .motion   (motion),
        .msgIndex (msgIndex),
        .msgByte  (msgByte)
    );

    cmdSequencer #(
        .gapCycles (gapCycles)
    ) u_cmdSequencer (
        .clk        (clk),
        .rst        (rst),
        .motionCode (motionCode),
        .msgByte    (msgByte),
        .txReady    (txReady),
        .motion     (motion),
        .msgIndex   (msgIndex),
        .txByte     (txByte),
        .txValid    (txValid),
        .status     (status)
    );

    uartTx #(
        .clksPerBit (clksPerBit),
        .parityMode (parityMode)
    ) u_uartTx (
        .clk     (clk),
        .rst     (rst),
        .txByte  (txByte),
        .txValid (txValid),
        .txReady (txReady),
        .txd     (txd)
    );

endmodule

`default_nettype wire

// File: hdl/motionPkg.sv
`default_nettype none

package motionPkg;

    // Motion codes from the host, 7 falls back to stop
    typedef enum logic [2:0] {
        STOP     = 3'd0,
        LEFT     = 3'd1,
        RIGHT    = 3'd2,
        FWD_SLOW = 3'd3,
        FWD_MED  = 3'd4,
        FWD_FAST = 3'd5,
        REVERSE  = 3'd6
    } motion_e;

    // Longest message is 27 bytes
    localparam int msgIndexW = 5;

    // One character out of the message store
    typedef struct packed {
        logic [7:0] data;           // ASCII character
        logic       last;           // Final newline of the message
    } msgByte_t;

    // Sender state seen from outside
    typedef struct packed {
        logic    busy;              // Message in flight
        logic    done;              // Single-cycle end of message
        motion_e activeMotion;      // Motion of current or last message
    } senderStatus_t;

endpackage

`default_nettype wire

// File: hdl/uartPkg.sv
`default_nettype none

package uartPkg;

    // Parity bit selection
    typedef enum logic [1:0] {
        NONE = 2'd0,                // No parity bit in the frame
        EVEN = 2'd1,
        ODD  = 2'd2
    } parity_e;

    // Transmitter frame states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,              // Line high, ready for a byte
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4
    } txState_e;

endpackage

`default_nettype wire

// File: hdl/uartTx.sv
`timescale 1ns/1ps
`default_nettype none

module uartTx import uartPkg::*; #(
    parameter int      clksPerBit = 434,            // At least 2
    parameter parity_e parityMode = NONE
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] txByte,
    input  logic       txValid,
    output logic       txReady,
    output logic       txd
);

    localparam int                timerW  = $clog2(clksPerBit);
    localparam logic [timerW-1:0] bitEnd  = timerW'(clksPerBit - 1);
    // Idle cycle of the handoff closes the stop bit
    localparam logic [timerW-1:0] stopEnd = timerW'(clksPerBit - 2);

    txState_e          state;
    logic [timerW-1:0] bitTimer;                    // Cycles into current bit
    logic [2:0]        bitCount;                    // Data bit number
    logic [7:0]        shiftReg;
    logic              parityAcc;
    logic              handoff;
    logic              bitDone;

    assign txReady = (state == IDLE);
    assign handoff = txValid && txReady;
    assign bitDone = (bitTimer == bitEnd);

    // Line level decoded straight from the state
    always_comb begin
        case (state)
            START:   txd = 1'b0;
            DATA:    txd = shiftReg[0];             // LSB first
            PARITY:  txd = parityAcc;
            default: txd = 1'b1;                    // Idle and stop
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            bitTimer <= '0;
            bitCount <= '0;
        end else begin
            bitTimer <= bitTimer + 1'b1;
            case (state)
                IDLE: begin
                    bitTimer <= '0;
                    if (handoff) begin
                        state <= START;
                    end
                end
                START: begin
                    if (bitDone) begin
                        state    <= DATA;
                        bitTimer <= '0;
                        bitCount <= '0;
                    end
                end
                DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) begin
                            state <= (parityMode == NONE) ? STOP : PARITY;
                        end
                    end
                end
                PARITY: begin
                    if (bitDone) begin
                        state    <= STOP;
                        bitTimer <= '0;
                    end
                end
                default: begin                      // STOP
                    if (bitTimer == stopEnd) begin
                        state    <= IDLE;
                        bitTimer <= '0;
                    end
                end
            endcase
        end
    end

    // Shifter and running parity
    always_ff @(posedge clk) begin
        if (handoff) begin
            shiftReg  <= txByte;
            parityAcc <= (parityMode == ODD);       // Odd starts from one
        end else if (state == DATA && bitDone) begin
            shiftReg  <= shiftReg >> 1;
            parityAcc <= parityAcc ^ shiftReg[0];
        end
    end

    // Line rests high whenever a byte can be taken
    idleHigh: assert property (@(posedge clk) disable iff (rst)
        txReady |-> txd)
        else $error("txd low while idle");

    // Start bit and busy follow a handoff on the next cycle
    startAfterLoad: assert property (@(posedge clk) disable iff (rst)
        handoff |=> !txReady && !txd)
        else $error("No start bit after handoff");

endmodule

`default_nettype wire

// File: src.f
hdl/motionPkg.sv
hdl/uartPkg.sv
hdl/cmdMessageRom.sv
hdl/cmdSequencer.sv
hdl/uartTx.sv
hdl/jsonUartTop.sv
dv/jsonUartTb.sv
